// File: Bender.yml
package:
  name: cpu

export_include_dirs:
  - verilog

sources:
  - verilog/cpuPkg.sv
  - verilog/cpuIfs.sv
  - verilog/fetchUnit.sv
  - verilog/controlUnit.sv
  - verilog/registerFile.sv
  - verilog/alu.sv
  - verilog/memStage.sv
  - verilog/cpu.sv
  - target: simulation
    files:
      - dv/cpu_props.sv
      - dv/cpu_tb.sv

// File: dv/cpu_props.sv
`timescale 1ns/1ns

module cpu_props (
  input logic              clk,
  input logic              reset,
  input cpuPkg::word_t     bAddr,
  input logic              meWriteEnable,
  input cpuPkg::memOp_t    exMemControl,
  input cpuPkg::jumpOp_t   jumpOp
);
  import cpuPkg::*;

  // pipeline stays quiet through reset and the cycle after it
  assert property (@(posedge clk) reset |=> (!meWriteEnable && exMemControl == MEM_NONE))
    else $error("write or load active while the pipeline is in reset");
  assert property (@(posedge clk) $fell(reset) |=> (!meWriteEnable && exMemControl == MEM_NONE))
    else $error("write or load active in the first cycle after reset");

  // sequential fetch unless decode redirected it
  assert property (@(posedge clk) disable iff (reset)
    (!reset && jumpOp == JUMP_NONE) |=> (bAddr == $past(bAddr) + word_t'(1)))
    else $error("fetch address skipped without a taken jump");

  assert property (@(posedge clk) disable iff (reset)
    (!$isunknown(exMemControl) && exMemControl inside {MEM_NONE, MEM_LOAD}))
    else $error("memory control in execute holds an illegal value");

endmodule

bind cpu cpu_props props (
  .clk           (clk),
  .reset         (reset),
  .bAddr         (bAddr),
  .meWriteEnable (meWriteEnable),
  .exMemControl  (exMemControl),
  .jumpOp        (jumpOp)
);

// File: dv/cpu_tb.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_tb;
  import cpuPkg::*;

  localparam int WordBits = `CPU_WORD_WIDTH;
  localparam int RegBits = `CPU_REG_COUNT * `CPU_WORD_WIDTH;
  localparam int ProgramCount = 6;

  logic clk;
  logic reset;
  word_t bAddr;
  word_t bMemRead;
  word_t aAddr;
  word_t aMemRead;
  word_t ifPc;
  word_t ifIr;
  word_t exCalResult;
  memOp_t exMemControl;
  regIndex_t meRegisterT;
  logic meWriteEnable;
  word_t meCalResult;
  logic tFlag;
  logic [RegBits-1:0] registerValue;

  word_t imem [256];
  word_t dmem [256];
  logic [15:0] lfsrState;
  logic [15:0] programSeed;
  int buildPc;

  // expected write stream and final state from the model
  regIndex_t expIndex [$];
  word_t expValue [$];
  memOp_t expControl [$];
  word_t expFetch [$];
  word_t expRegs [`CPU_REG_COUNT];
  logic expT;
  int modelCount;

  // execute state seen one cycle before its write-back
  word_t prevExResult;
  memOp_t prevExControl;

  int mismatchCount;
  int failureCount;
  int cycleCount;
  int cycleLimit;
  string testName;

  cpu i_cpu (.*);

  // both memories answer in the same cycle
  assign bMemRead = imem[bAddr[7:0]];
  assign aMemRead = dmem[aAddr[7:0]];

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic stepLfsr();
    logic feedback;
    feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], feedback};
    return feedback;
  endfunction

  function automatic int randomBits(int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      value = (value << 1) | int'(stepLfsr());
    end
    return value;
  endfunction

  function automatic word_t encode(opcode_t op, int t, int s, int m);
    return {op, 4'(t), 4'(s), 4'(m)};
  endfunction

  function automatic word_t encodeBranch(opcode_t op, int offset);
    return {op, 4'd0, 8'(offset)};
  endfunction

  task automatic emit(word_t instr);
    imem[buildPc] = instr;
    buildPc++;
  endtask

  // closing JR-to-self loop with a NOP slot, r10 holds its address
  task automatic emitEnd();
    int loopPc;
    loopPc = buildPc + 1;
    emit(encode(OP_MOVI, 10, loopPc >> 4, loopPc & 15));
    emit(encode(OP_JR, 0, 10, 0));
    emit(encode(OP_NOP, 0, 0, 0));
  endtask

  task automatic buildProgram(int id);
    opcode_t op;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
    end
    buildPc = 0;
    case (id)
      0: begin
        emit(encode(OP_MOVI, 1, 0, 5));
        emit(encode(OP_MOVI, 2, 15, 13));
        emit(encode(OP_ADD, 3, 1, 2));
        emit(encode(OP_SUB, 4, 3, 1));
        emit(encode(OP_AND, 5, 4, 3));
        emit(encode(OP_OR, 6, 5, 4));
        emit(encode(OP_XOR, 7, 6, 5));
        emit(encode(OP_ADD, 8, 7, 7));
        emit(encode(OP_SUB, 9, 8, 6));
      end
      1: begin
        emit(encode(OP_MOVI, 1, 8, 0));
        emit(encode(OP_MOVI, 2, 7, 15));
        emit(encode(OP_ADDI, 3, 1, 8));
        emit(encode(OP_ADDI, 4, 2, 7));
        emit(encode(OP_MOVI, 11, 3, 7));
        emit(encode(OP_MOVI, 15, 15, 15));
        emit(encode(OP_ADDI, 12, 2, 1));
        emit(encode(OP_ADD, 5, 11, 4));
      end
      2: begin
        // each load slot holds an independent instruction
        emit(encode(OP_MOVI, 1, 1, 0));
        emit(encode(OP_MOVI, 2, 2, 8));
        emit(encode(OP_LOAD, 3, 1, 0));
        emit(encode(OP_ADD, 5, 1, 2));
        emit(encode(OP_LOAD, 4, 1, 15));
        emit(encode(OP_MOVI, 6, 0, 1));
        emit(encode(OP_LOAD, 7, 2, 9));
        emit(encode(OP_ADDI, 8, 1, 3));
        emit(encode(OP_ADD, 9, 3, 4));
        emit(encode(OP_LOAD, 6, 2, 15));
        emit(encode(OP_NOP, 0, 0, 0));
      end
      3: begin
        emit(encode(OP_MOVI, 1, 0, 5));
        emit(encode(OP_MOVI, 2, 15, 14));
        emit(encode(OP_CMPGT, 0, 1, 2));
        emit(encodeBranch(OP_BT, 2));
        emit(encode(OP_ADDI, 3, 3, 1));
        emit(encode(OP_MOVI, 4, 6, 3));
        emit(encode(OP_CMPEQ, 0, 1, 2));
        emit(encodeBranch(OP_BT, 5));
        emit(encode(OP_ADDI, 5, 5, 2));
        emit(encodeBranch(OP_BF, 2));
        emit(encode(OP_ADDI, 6, 6, 3));
        emit(encode(OP_MOVI, 8, 5, 8));
        emit(encode(OP_CMPGT, 0, 2, 1));
        emit(encodeBranch(OP_BT, 3));
        emit(encode(OP_ADDI, 9, 9, 1));
        emit(encode(OP_CMPEQ, 0, 1, 1));
        emit(encodeBranch(OP_BF, 4));
        emit(encode(OP_NOP, 0, 0, 0));
      end
      4: begin
        emit(encode(OP_MOVI, 1, 0, 3));
        emit(encode(OP_ADDI, 2, 1, 5));
        emit(encode(OP_JR, 0, 2, 0));
        emit(encode(OP_MOVI, 3, 2, 1));
        emit(encode(OP_MOVI, 4, 2, 12));
        buildPc = 8;
        emit(encode(OP_ADDI, 5, 3, 1));
        emit(encode(OP_NOP, 0, 0, 0));
      end
      default: begin
        lfsrState = programSeed;
        for (int k = 0; k < 24; k++) begin
          // codes 1 to 9 cover ALU, immediate and compare
          op = opcode_t'(4'(randomBits(4) % 9 + 1));
          emit(encode(op, randomBits(4), randomBits(4), randomBits(4)));
        end
      end
    endcase
    emitEnd();
  endtask

  function automatic word_t readReg(int index);
    return (index < `CPU_REG_COUNT) ? expRegs[index] : '0;
  endfunction

  // sequential reference with delay slots
  function automatic void runModel();
    word_t pc;
    word_t npc;
    word_t target;
    word_t a;
    word_t b;
    word_t value;
    word_t addr;
    word_t ir;
    opcode_t op;
    memOp_t control;
    int t;
    logic taken;
    logic slotOfTaken;
    logic writes;
    logic endPending;
    logic done;
    expIndex.delete();
    expValue.delete();
    expControl.delete();
    expFetch.delete();
    for (int i = 0; i < `CPU_REG_COUNT; i++) begin
      expRegs[i] = '0;
    end
    expT = 1'b0;
    modelCount = 0;
    pc = `CPU_RESET_PC;
    npc = pc + word_t'(1);
    slotOfTaken = 1'b0;
    endPending = 1'b0;
    done = 1'b0;
    while (!done && modelCount < 1000) begin
      expFetch.push_back(pc);
      ir = imem[pc[7:0]];
      op = opcode_t'(ir[15:12]);
      t = ir[11:8];
      a = readReg(ir[7:4]);
      b = readReg(ir[3:0]);
      writes = 1'b0;
      taken = 1'b0;
      target = '0;
      value = '0;
      control = MEM_NONE;
      modelCount++;
      case (op)
        OP_ADD: begin
          value = a + b;
          writes = 1'b1;
        end
        OP_SUB: begin
          value = a - b;
          writes = 1'b1;
        end
        OP_AND: begin
          value = a & b;
          writes = 1'b1;
        end
        OP_OR: begin
          value = a | b;
          writes = 1'b1;
        end
        OP_XOR: begin
          value = a ^ b;
          writes = 1'b1;
        end
        OP_MOVI: begin
          value = word_t'($signed(ir[7:0]));
          writes = 1'b1;
        end
        OP_ADDI: begin
          value = a + word_t'($signed(ir[3:0]));
          writes = 1'b1;
        end
        OP_CMPEQ: expT = (a == b);
        OP_CMPGT: expT = ($signed(a) > $signed(b));
        OP_LOAD: begin
          addr = a + word_t'(ir[3:0]);
          value = dmem[addr[7:0]];
          writes = 1'b1;
          control = MEM_LOAD;
        end
        OP_BT: begin
          taken = expT;
          target = pc + word_t'(1) + word_t'($signed(ir[7:0]));
        end
        OP_BF: begin
          taken = !expT;
          target = pc + word_t'(1) + word_t'($signed(ir[7:0]));
        end
        OP_JR: begin
          taken = 1'b1;
          target = a;
        end
        default: ;
      endcase
      // jumps inside the slot of a taken jump are not followed
      if (slotOfTaken) begin
        taken = 1'b0;
      end
      if (writes) begin
        expIndex.push_back(regIndex_t'(t));
        expValue.push_back(value);
        expControl.push_back(control);
        if (t < `CPU_REG_COUNT) begin
          expRegs[t] = value;
        end
      end
      if (endPending) begin
        done = 1'b1;
      end
      if (taken && op == OP_JR && target == pc) begin
        endPending = 1'b1;
      end
      slotOfTaken = taken;
      pc = npc;
      npc = taken ? target : npc + word_t'(1);
    end
  endfunction

  task automatic checkWrite(regIndex_t expIdx, word_t expVal, regIndex_t actIdx, word_t actVal);
    if (expIdx !== actIdx || expVal !== actVal) begin
      mismatchCount++;
      $display("mismatch %s write: expected r%0d=%h actual r%0d=%h",
               testName, expIdx, expVal, actIdx, actVal);
    end
  endtask

  // load results come from memory, so only the control is compared for them
  task automatic checkExecute(memOp_t expCtl, word_t expVal, memOp_t actCtl, word_t actVal);
    if (expCtl !== actCtl) begin
      mismatchCount++;
      $display("mismatch %s execute control: expected %0d actual %0d",
               testName, expCtl, actCtl);
    end else if (expCtl == MEM_NONE && expVal !== actVal) begin
      mismatchCount++;
      $display("mismatch %s execute result: expected %h actual %h", testName, expVal, actVal);
    end
  endtask

  task automatic checkFetch(word_t expPc, word_t expIr, word_t actPc, word_t actIr);
    if (expPc !== actPc || expIr !== actIr) begin
      mismatchCount++;
      $display("mismatch %s fetch: expected pc %h ir %h actual pc %h ir %h",
               testName, expPc, expIr, actPc, actIr);
    end
  endtask

  task automatic checkRegisters(logic [RegBits-1:0] actual);
    word_t actWord;
    for (int i = 0; i < `CPU_REG_COUNT; i++) begin
      actWord = actual[i*WordBits +: WordBits];
      if (actWord !== expRegs[i]) begin
        mismatchCount++;
        $display("mismatch %s r%0d: expected %h actual %h", testName, i, expRegs[i], actWord);
      end
    end
  endtask

  task automatic checkFlag(logic expFlag, logic actFlag);
    if (expFlag !== actFlag) begin
      mismatchCount++;
      $display("mismatch %s T flag: expected %b actual %b", testName, expFlag, actFlag);
    end
  endtask

  // write-back stream and fetch order against the model
  always @(posedge clk) begin : compareStream
    regIndex_t nextIndex;
    word_t nextValue;
    memOp_t nextControl;
    word_t nextPc;
    if (!reset && meWriteEnable) begin
      if (expIndex.size() == 0) begin
        failureCount++;
        $display("%s: register write to r%0d when no write was expected", testName, meRegisterT);
      end else begin
        nextIndex = expIndex.pop_front();
        nextValue = expValue.pop_front();
        nextControl = expControl.pop_front();
        checkWrite(nextIndex, nextValue, meRegisterT, meCalResult);
        checkExecute(nextControl, nextValue, prevExControl, prevExResult);
      end
    end
    if (!reset && expFetch.size() != 0) begin
      nextPc = expFetch.pop_front();
      checkFetch(nextPc, imem[nextPc[7:0]], ifPc, ifIr);
    end
    prevExResult = exCalResult;
    prevExControl = exMemControl;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("timeout: run went past %0d cycles", cycleLimit);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic runProgram(int id, string name);
    @(posedge clk);
    reset <= 1'b1;
    @(posedge clk);
    testName = name;
    buildProgram(id);
    runModel();
    repeat (15) @(posedge clk);
    reset <= 1'b0;
    repeat (modelCount + 8) @(posedge clk);
    @(negedge clk);
    checkRegisters(registerValue);
    checkFlag(expT, tFlag);
    if (expIndex.size() != 0) begin
      failureCount++;
      $display("%s: %0d expected register writes never happened", name, expIndex.size());
    end
  endtask

  initial begin
    int budget;
    reset = 1'b1;
    mismatchCount = 0;
    failureCount = 0;
    cycleCount = 0;
    cycleLimit = 1000000;
    lfsrState = 16'd32677;
    for (int i = 0; i < 256; i++) begin
      dmem[i] = word_t'(randomBits(WordBits));
      imem[i] = '0;
    end
    programSeed = lfsrState;
    // limit from modelled lengths plus reset and drain
    budget = 0;
    for (int id = 0; id < ProgramCount; id++) begin
      buildProgram(id);
      runModel();
      budget += modelCount + 8 + 18;
    end
    cycleLimit = 2 * budget;
    runProgram(0, "aluBypass");
    runProgram(1, "immediates");
    runProgram(2, "loads");
    runProgram(3, "compareBranch");
    runProgram(4, "jumpRegister");
    runProgram(5, "randomProgram");
    $display("errors: %0d mismatches, %0d other failures", mismatchCount, failureCount);
    if (mismatchCount == 0 && failureCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+verilog
verilog/cpuPkg.sv
verilog/cpuIfs.sv
verilog/fetchUnit.sv
verilog/controlUnit.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/memStage.sv
verilog/cpu.sv
dv/cpu_props.sv
dv/cpu_tb.sv

// File: verilog/alu.sv
`timescale 1ns/1ns

module alu (
  input  logic          clk,
  input  logic          reset,
  decodeBus.execute     dec,
  input  cpuPkg::word_t originValueS,
  input  cpuPkg::word_t originValueM,
  input  cpuPkg::word_t meCalResult,
  execBus.alu           exec,
  output cpuPkg::word_t rs,
  output logic          tWriteEnable,
  output logic          tToWrite
);
  import cpuPkg::*;

  word_t rm;
  word_t result;

  function automatic word_t selectOperand(bypassSel_t sel, word_t fileValue, word_t exValue,
                                          word_t meValue, word_t immValue);
    case (sel)
      BYP_EX:  return exValue;
      BYP_ME:  return meValue;
      BYP_IMM: return immValue;
      default: return fileValue;
    endcase
  endfunction

  // operands in decode, after bypassing
  assign rs = selectOperand(dec.bypassS, originValueS, exec.exCalResult, meCalResult,
                            dec.immediate);
  assign rm = selectOperand(dec.bypassM, originValueM, exec.exCalResult, meCalResult,
                            dec.immediate);

  always_comb begin
    case (dec.aluOp)
      ALU_ADD: result = rs + rm;
      ALU_SUB: result = rs - rm;
      ALU_AND: result = rs & rm;
      ALU_OR:  result = rs | rm;
      ALU_XOR: result = rs ^ rm;
      default: result = rm;
    endcase
  end

  // compares go to T, written at the end of this cycle
  assign tWriteEnable = dec.tWriteEnable;
  assign tToWrite     = (dec.aluOp == ALU_CMPGT) ? ($signed(rs) > $signed(rm)) : (rs == rm);

  always_ff @(posedge clk) begin
    if (reset) begin
      exec.exWriteEnable <= 1'b0;
    end else begin
      exec.exWriteEnable <= dec.writeEnable;
    end
    exec.exCalResult <= result;
    exec.exRegisterT <= dec.registerT;
  end

endmodule

// File: verilog/controlUnit.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module controlUnit (
  input  logic               clk,
  input  logic               reset,
  input  cpuPkg::word_t      idIr,
  input  logic               tFlag,
  execBus.monitor            exec,
  input  cpuPkg::regIndex_t  meRegisterT,
  input  logic               meWriteEnable,
  decodeBus.control          dec,
  output cpuPkg::regIndex_t  registerS,
  output cpuPkg::regIndex_t  registerM,
  output cpuPkg::jumpOp_t    jumpOp,
  output cpuPkg::word_t      jumpOffset
);
  import cpuPkg::*;

  opcode_t opcode;
  jumpOp_t jumpRequest;
  logic    useImmediate;
  logic    inDelaySlot;

  // nearest producer wins; indices past the file always read zero
  function automatic bypassSel_t pickSource(regIndex_t index, regIndex_t exT, logic exWe,
                                            regIndex_t meT, logic meWe);
    if (index >= regIndex_t'(`CPU_REG_COUNT)) begin
      return BYP_FILE;
    end else if (exWe && exT == index) begin
      return BYP_EX;
    end else if (meWe && meT == index) begin
      return BYP_ME;
    end
    return BYP_FILE;
  endfunction

  assign opcode     = opcode_t'(idIr[`CPU_OPCODE_MSB:`CPU_OPCODE_LSB]);
  assign registerS  = idIr[7:4];
  assign registerM  = idIr[3:0];
  assign jumpOffset = word_t'($signed(idIr[7:0]));

  always_comb begin
    dec.aluOp        = ALU_PASS;
    dec.immediate    = '0;
    dec.registerT    = idIr[11:8];
    dec.writeEnable  = 1'b0;
    dec.tWriteEnable = 1'b0;
    dec.memOp        = MEM_NONE;
    useImmediate     = 1'b0;
    jumpRequest      = JUMP_NONE;
    case (opcode)
      OP_ADD: begin
        dec.aluOp       = ALU_ADD;
        dec.writeEnable = 1'b1;
      end
      OP_SUB: begin
        dec.aluOp       = ALU_SUB;
        dec.writeEnable = 1'b1;
      end
      OP_AND: begin
        dec.aluOp       = ALU_AND;
        dec.writeEnable = 1'b1;
      end
      OP_OR: begin
        dec.aluOp       = ALU_OR;
        dec.writeEnable = 1'b1;
      end
      OP_XOR: begin
        dec.aluOp       = ALU_XOR;
        dec.writeEnable = 1'b1;
      end
      OP_MOVI: begin
        dec.immediate   = word_t'($signed(idIr[7:0]));
        dec.writeEnable = 1'b1;
        useImmediate    = 1'b1;
      end
      OP_ADDI: begin
        dec.aluOp       = ALU_ADD;
        dec.immediate   = word_t'($signed(idIr[3:0]));
        dec.writeEnable = 1'b1;
        useImmediate    = 1'b1;
      end
      OP_CMPEQ: begin
        dec.aluOp        = ALU_CMPEQ;
        dec.tWriteEnable = 1'b1;
      end
      OP_CMPGT: begin
        dec.aluOp        = ALU_CMPGT;
        dec.tWriteEnable = 1'b1;
      end
      OP_LOAD: begin
        // load offset is unsigned
        dec.immediate   = word_t'(idIr[3:0]);
        dec.writeEnable = 1'b1;
        dec.memOp       = MEM_LOAD;
      end
      OP_BT: jumpRequest = tFlag ? JUMP_REL : JUMP_NONE;
      OP_BF: jumpRequest = tFlag ? JUMP_NONE : JUMP_REL;
      OP_JR: jumpRequest = JUMP_REG;
      default: ;
    endcase
    dec.bypassS = pickSource(registerS, exec.exRegisterT, exec.exWriteEnable,
                             meRegisterT, meWriteEnable);
    dec.bypassM = useImmediate ? BYP_IMM
                               : pickSource(registerM, exec.exRegisterT, exec.exWriteEnable,
                                            meRegisterT, meWriteEnable);
  end

  // a jump sitting in the slot of a taken jump is not followed
  assign jumpOp = inDelaySlot ? JUMP_NONE : jumpRequest;

  always_ff @(posedge clk) begin
    if (reset) begin
      inDelaySlot <= 1'b0;
    end else begin
      inDelaySlot <= (jumpOp != JUMP_NONE);
    end
  end

endmodule

// File: verilog/cpu.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu (
  input  logic                                      clk,
  input  logic                                      reset,
  output cpuPkg::word_t                             bAddr,
  input  cpuPkg::word_t                             bMemRead,
  output cpuPkg::word_t                             aAddr,
  input  cpuPkg::word_t                             aMemRead,
  output cpuPkg::word_t                             ifPc,
  output cpuPkg::word_t                             ifIr,
  output cpuPkg::word_t                             exCalResult,
  output cpuPkg::memOp_t                            exMemControl,
  output cpuPkg::regIndex_t                         meRegisterT,
  output logic                                      meWriteEnable,
  output cpuPkg::word_t                             meCalResult,
  output logic                                      tFlag,
  output logic [`CPU_REG_COUNT*`CPU_WORD_WIDTH-1:0] registerValue
);
  import cpuPkg::*;

  word_t     idPc;
  word_t     idIr;
  word_t     rs;
  word_t     jumpOffset;
  jumpOp_t   jumpOp;
  regIndex_t registerS;
  regIndex_t registerM;
  word_t     originValueS;
  word_t     originValueM;
  logic      tWriteEnable;
  logic      tToWrite;

  decodeBus decBus ();
  execBus   exBus ();

  fetchUnit fetch (
    .clk          (clk),
    .reset        (reset),
    .jumpOp       (jumpOp),
    .jumpOffset   (jumpOffset),
    .jumpRegister (rs),
    .bMemRead     (bMemRead),
    .bAddr        (bAddr),
    .ifPc         (ifPc),
    .ifIr         (ifIr),
    .idPc         (idPc),
    .idIr         (idIr)
  );

  controlUnit control (
    .clk           (clk),
    .reset         (reset),
    .idIr          (idIr),
    .tFlag         (tFlag),
    .exec          (exBus.monitor),
    .meRegisterT   (meRegisterT),
    .meWriteEnable (meWriteEnable),
    .dec           (decBus.control),
    .registerS     (registerS),
    .registerM     (registerM),
    .jumpOp        (jumpOp),
    .jumpOffset    (jumpOffset)
  );

  registerFile regFile (
    .clk           (clk),
    .reset         (reset),
    .registerS     (registerS),
    .registerM     (registerM),
    .writeEnable   (meWriteEnable),
    .registerT     (meRegisterT),
    .writeValue    (meCalResult),
    .tWriteEnable  (tWriteEnable),
    .tToWrite      (tToWrite),
    .originValueS  (originValueS),
    .originValueM  (originValueM),
    .tFlag         (tFlag),
    .registerValue (registerValue)
  );

  alu calculator (
    .clk          (clk),
    .reset        (reset),
    .dec          (decBus.execute),
    .originValueS (originValueS),
    .originValueM (originValueM),
    .meCalResult  (meCalResult),
    .exec         (exBus.alu),
    .rs           (rs),
    .tWriteEnable (tWriteEnable),
    .tToWrite     (tToWrite)
  );

  memStage memory (
    .clk           (clk),
    .reset         (reset),
    .dec           (decBus.memory),
    .rs            (rs),
    .exec          (exBus.memory),
    .aMemRead      (aMemRead),
    .aAddr         (aAddr),
    .meCalResult   (meCalResult),
    .meRegisterT   (meRegisterT),
    .meWriteEnable (meWriteEnable)
  );

  // execute state made visible at the top
  assign exCalResult  = exBus.exCalResult;
  assign exMemControl = exBus.exMemControl;

endmodule

// File: verilog/cpuIfs.sv
`timescale 1ns/1ns

// controls of the instruction now in decode
interface decodeBus;
  import cpuPkg::*;

  aluOp_t     aluOp;
  word_t      immediate;
  regIndex_t  registerT;
  logic       writeEnable;
  logic       tWriteEnable;
  memOp_t     memOp;
  bypassSel_t bypassS;
  bypassSel_t bypassM;

  modport control (
    output aluOp, immediate, registerT, writeEnable, tWriteEnable, memOp, bypassS, bypassM
  );
  modport execute (
    input aluOp, immediate, registerT, writeEnable, tWriteEnable, bypassS, bypassM
  );
  modport memory (input memOp, immediate);
endinterface

// execute-stage state
interface execBus;
  import cpuPkg::*;

  word_t     exCalResult;
  regIndex_t exRegisterT;
  logic      exWriteEnable;
  memOp_t    exMemControl;

  modport alu (output exCalResult, exRegisterT, exWriteEnable);
  modport memory (input exCalResult, exRegisterT, exWriteEnable, output exMemControl);
  modport monitor (input exRegisterT, exWriteEnable);
endinterface

// File: verilog/cpuPkg.sv
`include "cpu_cfg.svh"

package cpuPkg;

  typedef logic [`CPU_WORD_WIDTH-1:0] word_t;
  typedef logic [3:0] regIndex_t;

  // codes 14 and 15 are unused and decode as NOP
  typedef enum logic [3:0] {
    OP_NOP   = 4'd0,
    OP_ADD   = 4'd1,
    OP_SUB   = 4'd2,
    OP_AND   = 4'd3,
    OP_OR    = 4'd4,
    OP_XOR   = 4'd5,
    OP_MOVI  = 4'd6,
    OP_ADDI  = 4'd7,
    OP_CMPEQ = 4'd8,
    OP_CMPGT = 4'd9,
    OP_LOAD  = 4'd10,
    OP_BT    = 4'd11,
    OP_BF    = 4'd12,
    OP_JR    = 4'd13
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_CMPEQ, ALU_CMPGT
  } aluOp_t;

  typedef enum logic [1:0] {MEM_NONE, MEM_LOAD} memOp_t;

  typedef enum logic [2:0] {JUMP_NONE, JUMP_REL, JUMP_REG} jumpOp_t;

  // immediate source only used for the second operand
  typedef enum logic [1:0] {BYP_FILE, BYP_EX, BYP_ME, BYP_IMM} bypassSel_t;

endpackage

// File: verilog/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// width of a data word and of both address buses
`define CPU_WORD_WIDTH 16

// general registers, higher indices read as zero
`define CPU_REG_COUNT 11

// first fetch address after reset
`define CPU_RESET_PC 0

// opcode field position inside an instruction word
`define CPU_OPCODE_MSB 15
`define CPU_OPCODE_LSB 12

`endif

// File: verilog/fetchUnit.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module fetchUnit (
  input  logic              clk,
  input  logic              reset,
  input  cpuPkg::jumpOp_t   jumpOp,
  input  cpuPkg::word_t     jumpOffset,
  input  cpuPkg::word_t     jumpRegister,
  input  cpuPkg::word_t     bMemRead,
  output cpuPkg::word_t     bAddr,
  output cpuPkg::word_t     ifPc,
  output cpuPkg::word_t     ifIr,
  output cpuPkg::word_t     idPc,
  output cpuPkg::word_t     idIr
);
  import cpuPkg::*;

  word_t pc;
  word_t nextPc;

  // relative targets count from the slot after the branch
  always_comb begin
    case (jumpOp)
      JUMP_REL: nextPc = idPc + word_t'(1) + jumpOffset;
      JUMP_REG: nextPc = jumpRegister;
      default:  nextPc = pc + word_t'(1);
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc   <= word_t'(`CPU_RESET_PC);
      // all-zero word decodes as NOP
      idIr <= '0;
    end else begin
      pc   <= nextPc;
      idIr <= bMemRead;
    end
    idPc <= pc;
  end

  // instruction memory answers in the same cycle
  assign bAddr = pc;
  assign ifPc  = pc;
  assign ifIr  = bMemRead;

endmodule

// File: verilog/memStage.sv
`timescale 1ns/1ns

module memStage (
  input  logic              clk,
  input  logic              reset,
  decodeBus.memory          dec,
  input  cpuPkg::word_t     rs,
  execBus.memory            exec,
  input  cpuPkg::word_t     aMemRead,
  output cpuPkg::word_t     aAddr,
  output cpuPkg::word_t     meCalResult,
  output cpuPkg::regIndex_t meRegisterT,
  output logic              meWriteEnable
);
  import cpuPkg::*;

  // load address and control, captured with the execute result
  always_ff @(posedge clk) begin
    if (reset) begin
      exec.exMemControl <= MEM_NONE;
    end else begin
      exec.exMemControl <= dec.memOp;
    end
    aAddr <= rs + dec.immediate;
  end

  // data memory answers within the cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      meWriteEnable <= 1'b0;
    end else begin
      meWriteEnable <= exec.exWriteEnable;
    end
    meRegisterT <= exec.exRegisterT;
    meCalResult <= (exec.exMemControl == MEM_LOAD) ? aMemRead : exec.exCalResult;
  end

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module registerFile (
  input  logic                                      clk,
  input  logic                                      reset,
  input  cpuPkg::regIndex_t                         registerS,
  input  cpuPkg::regIndex_t                         registerM,
  input  logic                                      writeEnable,
  input  cpuPkg::regIndex_t                         registerT,
  input  cpuPkg::word_t                             writeValue,
  input  logic                                      tWriteEnable,
  input  logic                                      tToWrite,
  output cpuPkg::word_t                             originValueS,
  output cpuPkg::word_t                             originValueM,
  output logic                                      tFlag,
  output logic [`CPU_REG_COUNT*`CPU_WORD_WIDTH-1:0] registerValue
);
  import cpuPkg::*;

  localparam regIndex_t LastIndex = regIndex_t'(`CPU_REG_COUNT - 1);

  word_t regs [`CPU_REG_COUNT];

  // out-of-range indices read back as zero
  assign originValueS = (registerS <= LastIndex) ? regs[registerS] : '0;
  assign originValueM = (registerM <= LastIndex) ? regs[registerM] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
      tFlag <= 1'b0;
    end else begin
      if (writeEnable && registerT <= LastIndex) begin
        regs[registerT] <= writeValue;
      end
      if (tWriteEnable) begin
        tFlag <= tToWrite;
      end
    end
  end

  // register 0 in the lowest word
  always_comb begin
    for (int i = 0; i < `CPU_REG_COUNT; i++) begin
      registerValue[i*`CPU_WORD_WIDTH +: `CPU_WORD_WIDTH] = regs[i];
    end
  end

endmodule
